//--- common/ctl_defines.svh
`ifndef CTL_DEFINES_SVH
`define CTL_DEFINES_SVH

// Microword magic number field
`define CTL_MAGIC_W 9

// Diagnostic function code, octal 1+3+3 bits
`define CTL_DS_W 7

// Diagnostic bus readback word
`define CTL_SLICE_W 5

`endif

//--- common/ctlCramPkg.sv
`default_nettype none

package ctlCramPkg;

  // Dispatch field, octal codes
  typedef enum logic [4:0] {
    dispNone   = 5'o00,
    dispAread  = 5'o02,
    dispReturn = 5'o03,
    dispNicond = 5'o06,
    dispMul    = 5'o30,
    dispDiv    = 5'o31,
    dispNorm   = 5'o35,
    dispEaMod  = 5'o36
  } dispCodeT;

  // Special function field
  typedef enum logic [4:0] {
    specNone        = 5'o00,
    specInhCry18    = 5'o11,
    specMqShift     = 5'o12,
    specLoadPc      = 5'o15,
    specGenCry18    = 5'o17,
    specStackUpdate = 5'o20,
    specArlInd      = 5'o22,
    specSaveFlags   = 5'o25,
    specAdLong      = 5'o27
  } specCodeT;

  // Low three bits of the condition field
  typedef enum logic [2:0] {
    condNone     = 3'd0,
    condArllLoad = 3'd1,
    condArlrLoad = 3'd2,
    condArrLoad  = 3'd3,
    condArClr    = 3'd4,
    condArxClr   = 3'd5,
    condArlInd   = 3'd6,
    condRegCtl   = 3'd7
  } condCodeT;

endpackage

`default_nettype wire

//--- common/ctlDiagPkg.sv
`default_nettype none
`include "ctl_defines.svh"

package ctlDiagPkg;

  // Function code as octal digits, e.g. 076 or 10x
  typedef struct packed {
    logic       hi;
    logic [2:0] mid;
    logic [2:0] lo;
  } diagFuncT;

  // Bit 0 is the leftmost bus bit
  typedef logic [0:`CTL_SLICE_W-1] sliceT;

  typedef logic [2:0] readSelT;

  // Loaded by function 076
  typedef struct packed {
    logic memReset;
    logic channelClkStop;
    logic ldEbusReg;
    logic forceExtend;
    logic diag4;
  } diagCtlRegT;

endpackage

`default_nettype wire

//--- microDecode/microDecode.sv
`timescale 1ns/1ps
`default_nettype none
`include "ctl_defines.svh"

module microDecode (
  input  wire logic                    CTL,
  input  wire logic                    reset,
  input  wire ctlCramPkg::dispCodeT    disp,
  input  wire ctlCramPkg::specCodeT    spec,
  input  wire ctlCramPkg::condCodeT    cond,
  input  wire logic                    condEn,
  input  wire logic [`CTL_MAGIC_W-1:0] magic,
  input  wire logic [2:0]              arField,
  input  wire logic [2:0]              arxField,
  input  wire logic                    mqField,
  input  wire logic                    shortStack,
  input  wire logic                    ea18Bit,
  input  wire logic                    ea23Bit,
  input  wire logic                    arx18,
  input  wire logic                    sbrCall,
  output logic [2:0]                   arlSel,
  output logic [1:0]                   arrSel,
  output logic [1:0]                   arxSel,
  output logic                         ar00to08Load,
  output logic                         ar09to17Load,
  output logic                         arrLoad,
  output logic                         arxLoad,
  output logic                         ar00to11Clr,
  output logic                         ar12to17Clr,
  output logic [1:0]                   mqSel,
  output logic [1:0]                   mqmSel,
  output logic                         adLong,
  output logic                         genCry18,
  output logic                         loadPc,
  output logic                         dispRet,
  output logic [2:0]                   regCtl
);
  import ctlCramPkg::*;

  logic [7:0] condHit;
  logic       isAread;
  logic       isReturn;
  logic       isMul;
  logic       isDiv;
  logic       isNorm;
  logic       isEaMod;
  logic       isNicond;
  logic       isMqShift;
  logic       isLoadPc;
  logic       isGenCry18;
  logic       isStackUpdate;
  logic       isAdLong;
  logic       arlInd;
  logic [2:0] regCtlNext;
  logic       regCtlMqClr;
  logic       regCtlMqMath;
  logic [2:0] arlSelNext;
  logic [1:0] arrSelNext;
  logic       arClr;
  logic       arxClr;
  logic       mqClr;
  logic       clrRight;
  logic       clrLeft;
  logic       leftLoad;
  logic       mqmEn;
  logic       mqResetTerm;
  logic       mqMathTerm;

  // One-hot condition, gated by the condition enable
  assign condHit = condEn ? (8'b1 << cond) : 8'b0;

  assign isAread  = (disp == dispAread);
  assign isReturn = (disp == dispReturn);
  assign isMul    = (disp == dispMul);
  assign isDiv    = (disp == dispDiv);
  assign isNorm   = (disp == dispNorm);
  assign isEaMod  = (disp == dispEaMod);
  assign isNicond = (disp == dispNicond);

  assign isMqShift     = (spec == specMqShift);
  assign isLoadPc      = (spec == specLoadPc);
  assign isGenCry18    = (spec == specGenCry18);
  assign isStackUpdate = (spec == specStackUpdate);
  assign isAdLong      = (spec == specAdLong);

  assign regCtlNext   = magic[8:6] & {3{condHit[condRegCtl]}};
  assign regCtlMqClr  = magic[1] & condHit[condRegCtl];
  assign regCtlMqMath = magic[0] & condHit[condRegCtl];

  // Indirect mode takes selects and clears from magic
  assign arlInd     = (spec == specArlInd) | condHit[condArlInd];
  assign arlSelNext = arlInd ? magic[8:6] : arField;
  assign arClr      = arlInd ? magic[4] : condHit[condArClr];
  assign arxClr     = arlInd ? magic[5] : condHit[condArxClr];
  assign mqClr      = arlInd & magic[3];

  assign arrSelNext = {arField[1] | isAread, arField[0]};

  assign clrRight = reset | ea18Bit | arClr | (isEaMod & arx18);
  assign clrLeft  = clrRight | ea23Bit;
  assign leftLoad = clrLeft | (|arlSelNext);

  // MQ mux vs MQM mux steering
  assign mqmEn       = mqField | reset;
  assign mqResetTerm = reset | regCtlMqClr | mqClr;
  assign mqMathTerm  = mqClr | regCtlMqMath | isMqShift | isMul | isDiv;

  always_ff @(posedge CTL) begin
    if (reset) begin
      arlSel       <= '0;
      arrSel       <= '0;
      arxSel       <= '0;
      ar00to08Load <= 1'b0;
      ar09to17Load <= 1'b0;
      arrLoad      <= 1'b0;
      arxLoad      <= 1'b0;
      ar00to11Clr  <= 1'b0;
      ar12to17Clr  <= 1'b0;
      mqSel        <= '0;
      mqmSel       <= '0;
      adLong       <= 1'b0;
      genCry18     <= 1'b0;
      loadPc       <= 1'b0;
      dispRet      <= 1'b0;
      regCtl       <= '0;
    end else begin
      arlSel       <= arlSelNext;
      arrSel       <= arrSelNext;
      arxSel       <= arxField[1:0];
      ar00to08Load <= condHit[condArllLoad] | regCtlNext[2] | leftLoad;
      ar09to17Load <= condHit[condArlrLoad] | regCtlNext[1] | leftLoad;
      arrLoad      <= condHit[condArrLoad] | regCtlNext[0] | (|arrSelNext) | arClr;
      arxLoad      <= arxField[2] | (|arxField[1:0]) | arxClr;
      ar00to11Clr  <= clrLeft;
      ar12to17Clr  <= clrRight;
      mqSel        <= {~mqmEn & mqResetTerm, ~mqmEn & mqMathTerm};
      mqmSel       <= {mqmEn & mqResetTerm, mqmEn & mqMathTerm};
      adLong       <= isMul | isDiv | isNorm | isAdLong | isMqShift;
      genCry18     <= isGenCry18 | (isStackUpdate & shortStack);
      loadPc       <= ~sbrCall & (isLoadPc | isNicond);
      dispRet      <= sbrCall & isReturn;
      regCtl       <= regCtlNext;
    end
  end

endmodule

`default_nettype wire

//--- diagDecode/diagDecode.sv
`timescale 1ns/1ps
`default_nettype none
`include "ctl_defines.svh"

module diagDecode (
  input  wire logic                    CTL,
  input  wire logic                    reset,
  input  wire ctlDiagPkg::diagFuncT    ebusDs,
  input  wire logic                    diagStrobe,
  input  wire logic [`CTL_MAGIC_W-1:0] magic,
  input  wire logic                    condDiagFunc,
  input  wire ctlDiagPkg::sliceT       ebusDataIn,
  output logic                         diagRead,
  output ctlDiagPkg::readSelT          readSel,
  output ctlDiagPkg::diagCtlRegT       diagCtl,
  output logic                         channelClkStop,
  output logic [2:0]                   diagFunc
);
  import ctlDiagPkg::*;

  logic     consoleCtl;
  diagFuncT selFunc;
  logic     selStrobe;
  logic     load076;
  logic     read10x;

  // Console owns the code when either top bit is set
  assign consoleCtl = ebusDs.hi | ebusDs.mid[2];

  // Otherwise the microword's magic field supplies it
  assign selFunc   = consoleCtl ? ebusDs : diagFuncT'(magic[`CTL_DS_W-1:0]);
  assign selStrobe = consoleCtl ? diagStrobe : condDiagFunc;

  // Load 076 only ever comes from the console
  assign load076 = diagStrobe && (ebusDs == 7'o076);

  // Read 10x from either source
  assign read10x = selStrobe && selFunc.hi && (selFunc.mid == 3'o0);

  always_ff @(posedge CTL) begin
    if (reset) begin
      diagRead <= 1'b0;
      readSel  <= '0;
      diagFunc <= '0;
    end else begin
      diagRead <= read10x;
      diagFunc <= selFunc.lo;
      if (read10x) begin
        readSel <= selFunc.lo;
      end
    end
  end

  // Diagnostic control register
  always_ff @(posedge CTL) begin
    if (reset) begin
      diagCtl <= '0;
    end else if (load076) begin
      diagCtl <= diagCtlRegT'(ebusDataIn);
    end
  end

  assign channelClkStop = diagCtl.channelClkStop;

endmodule

`default_nettype wire

//--- source/ebusReadback.sv
`timescale 1ns/1ps
`default_nettype none

module ebusReadback (
  input  wire logic                   CTL,
  input  wire logic                   reset,
  input  wire logic                   diagRead,
  input  wire ctlDiagPkg::readSelT    readSel,
  input  wire logic [2:0]             arlSel,
  input  wire logic [1:0]             arrSel,
  input  wire logic [1:0]             arxSel,
  input  wire logic                   ar00to08Load,
  input  wire logic                   ar09to17Load,
  input  wire logic                   arrLoad,
  input  wire logic                   arxLoad,
  input  wire logic                   ar00to11Clr,
  input  wire logic                   ar12to17Clr,
  input  wire logic [1:0]             mqSel,
  input  wire logic [1:0]             mqmSel,
  input  wire logic                   adLong,
  input  wire logic                   genCry18,
  input  wire logic                   loadPc,
  input  wire logic                   dispRet,
  input  wire logic [2:0]             regCtl,
  input  wire ctlDiagPkg::diagCtlRegT diagCtl,
  output logic                        ebusDriving,
  output ctlDiagPkg::sliceT           ebusData
);
  import ctlDiagPkg::*;

  sliceT slice;

  // Bus stays zero unless a 10x read is active
  always_comb begin
    slice = '0;
    if (diagRead) begin
      case (readSel)
        3'd0:    slice = {dispRet, genCry18, arlSel[1], arrLoad, ar00to08Load};
        3'd1:    slice = {loadPc, adLong, arlSel[0], arrLoad, ar09to17Load};
        3'd2:    slice = {regCtl[2], mqmSel[1], arrSel[1], arxLoad, arlSel[2]};
        3'd3:    slice = {regCtl[1], mqmSel[0], arrSel[0], mqSel[1], ar00to11Clr};
        3'd4:    slice = {regCtl[0], mqSel[0], arxSel[1], arxSel[0], ar12to17Clr};
        default: slice = sliceT'(diagCtl);
      endcase
    end
  end

  always_ff @(posedge CTL) begin
    if (reset) begin
      ebusDriving <= 1'b0;
      ebusData    <= '0;
    end else begin
      ebusDriving <= diagRead;
      ebusData    <= slice;
    end
  end

endmodule

`default_nettype wire

//--- source/ctlTop.sv
`timescale 1ns/1ps
`default_nettype none
`include "ctl_defines.svh"

module ctlTop (
  input  wire logic                    CTL,
  input  wire logic                    reset,
  input  wire ctlCramPkg::dispCodeT    disp,
  input  wire ctlCramPkg::specCodeT    spec,
  input  wire ctlCramPkg::condCodeT    cond,
  input  wire logic                    condEn,
  input  wire logic [`CTL_MAGIC_W-1:0] magic,
  input  wire logic [2:0]              arField,
  input  wire logic [2:0]              arxField,
  input  wire logic                    mqField,
  input  wire logic                    shortStack,
  input  wire logic                    ea18Bit,
  input  wire logic                    ea23Bit,
  input  wire logic                    arx18,
  input  wire logic                    sbrCall,
  input  wire logic                    condDiagFunc,
  input  wire ctlDiagPkg::diagFuncT    ebusDs,
  input  wire logic                    diagStrobe,
  input  wire ctlDiagPkg::sliceT       ebusDataIn,
  output logic [2:0]                   arlSel,
  output logic [1:0]                   arrSel,
  output logic [1:0]                   arxSel,
  output logic                         ar00to08Load,
  output logic                         ar09to17Load,
  output logic                         arrLoad,
  output logic                         arxLoad,
  output logic                         ar00to11Clr,
  output logic                         ar12to17Clr,
  output logic [1:0]                   mqSel,
  output logic [1:0]                   mqmSel,
  output logic                         adLong,
  output logic                         genCry18,
  output logic                         loadPc,
  output logic                         dispRet,
  output logic [2:0]                   regCtl,
  output ctlDiagPkg::diagCtlRegT       diagCtl,
  output logic                         channelClkStop,
  output logic [2:0]                   diag,
  output logic                         ebusDriving,
  output ctlDiagPkg::sliceT            ebusData
);
  import ctlDiagPkg::*;

  logic    diagRead;
  readSelT readSel;

  microDecode microDec (.*);

  diagDecode diagDec (
    .CTL            (CTL),
    .reset          (reset),
    .ebusDs         (ebusDs),
    .diagStrobe     (diagStrobe),
    .magic          (magic),
    .condDiagFunc   (condDiagFunc),
    .ebusDataIn     (ebusDataIn),
    .diagRead       (diagRead),
    .readSel        (readSel),
    .diagCtl        (diagCtl),
    .channelClkStop (channelClkStop),
    .diagFunc       (diag)
  );

  // Control state back onto the diagnostic bus
  ebusReadback readback (.*);

endmodule

`default_nettype wire

//--- tb/ctlTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "ctl_defines.svh"

module ctlTb;
  import ctlCramPkg::*;
  import ctlDiagPkg::*;

  localparam int vectorCount  = 35;
  localparam int vectorWords  = 17;
  localparam int resetTimeout = 20;

  logic                    CTL;
  logic                    reset;
  dispCodeT                disp;
  specCodeT                spec;
  condCodeT                cond;
  logic                    condEn;
  logic [`CTL_MAGIC_W-1:0] magic;
  logic [2:0]              arField;
  logic [2:0]              arxField;
  logic                    mqField;
  logic                    shortStack;
  logic                    ea18Bit;
  logic                    ea23Bit;
  logic                    arx18;
  logic                    sbrCall;
  logic                    condDiagFunc;
  diagFuncT                ebusDs;
  logic                    diagStrobe;
  sliceT                   ebusDataIn;
  logic [2:0]              arlSel;
  logic [1:0]              arrSel;
  logic [1:0]              arxSel;
  logic                    ar00to08Load;
  logic                    ar09to17Load;
  logic                    arrLoad;
  logic                    arxLoad;
  logic                    ar00to11Clr;
  logic                    ar12to17Clr;
  logic [1:0]              mqSel;
  logic [1:0]              mqmSel;
  logic                    adLong;
  logic                    genCry18;
  logic                    loadPc;
  logic                    dispRet;
  logic [2:0]              regCtl;
  diagCtlRegT              diagCtl;
  logic                    channelClkStop;
  logic [2:0]              diag;
  logic                    ebusDriving;
  sliceT                   ebusData;

  logic [15:0] patterns [0:vectorCount*vectorWords-1];
  int          currentVector = -1;
  int          checkCount = 0;
  int          checkErrors = 0;
  int          waitErrors = 0;
  int          fileErrors = 0;

  ctlTop DUT (.*);

  always #50 CTL = ~CTL;

  task automatic checkBit(input string name, input logic got, input logic exp);
    checkCount++;
    if (got !== exp) begin
      checkErrors++;
      $display("CHECK FAILED %s vector %0d got 0x%h expected 0x%h",
               name, currentVector, got, exp);
    end
  endtask

  task automatic checkSelect(input string name, input logic [2:0] got, input logic [2:0] exp);
    checkCount++;
    if (got !== exp) begin
      checkErrors++;
      $display("CHECK FAILED %s vector %0d got 0x%h expected 0x%h",
               name, currentVector, got, exp);
    end
  endtask

  task automatic checkSlice(input string name, input sliceT got, input sliceT exp);
    checkCount++;
    if (got !== exp) begin
      checkErrors++;
      $display("CHECK FAILED %s vector %0d got 0x%h expected 0x%h",
               name, currentVector, got, exp);
    end
  endtask

  task automatic checkDiagCtl(input string name, input diagCtlRegT got, input diagCtlRegT exp);
    checkCount++;
    if (got !== exp) begin
      checkErrors++;
      $display("CHECK FAILED %s vector %0d got 0x%h expected 0x%h",
               name, currentVector, got, exp);
    end
  endtask

  function automatic logic outputsKnown();
    return !$isunknown({arlSel, arrSel, arxSel, ar00to08Load, ar09to17Load, arrLoad, arxLoad,
                        ar00to11Clr, ar12to17Clr, mqSel, mqmSel, adLong, genCry18, loadPc,
                        dispRet, regCtl, diagCtl, ebusDriving, ebusData});
  endfunction

  task automatic checkResetState();
    checkSelect("arlSel", arlSel, 3'b000);
    checkSelect("arrSel", {1'b0, arrSel}, 3'b000);
    checkSelect("arxSel", {1'b0, arxSel}, 3'b000);
    checkSelect("mqSel", {1'b0, mqSel}, 3'b000);
    checkSelect("mqmSel", {1'b0, mqmSel}, 3'b000);
    checkSelect("regCtl", regCtl, 3'b000);
    checkBit("ar00to08Load", ar00to08Load, 1'b0);
    checkBit("ar09to17Load", ar09to17Load, 1'b0);
    checkBit("arrLoad", arrLoad, 1'b0);
    checkBit("arxLoad", arxLoad, 1'b0);
    checkBit("ar00to11Clr", ar00to11Clr, 1'b0);
    checkBit("ar12to17Clr", ar12to17Clr, 1'b0);
    checkBit("adLong", adLong, 1'b0);
    checkBit("genCry18", genCry18, 1'b0);
    checkBit("loadPc", loadPc, 1'b0);
    checkBit("dispRet", dispRet, 1'b0);
    checkBit("ebusDriving", ebusDriving, 1'b0);
    checkSlice("ebusData", ebusData, '0);
    checkDiagCtl("diagCtl", diagCtl, '0);
  endtask

  initial begin
    int         base;
    int         waitCount;
    logic [5:0] expFlags;
    logic [2:0] expArlSel;
    logic [2:0] expDiag;
    logic       expDriving;
    sliceT      expData;
    diagCtlRegT expDiagCtl;

    CTL          = 1'b0;
    reset        = 1'b1;
    disp         = dispNone;
    spec         = specNone;
    cond         = condNone;
    condEn       = 1'b0;
    magic        = '0;
    arField      = '0;
    arxField     = '0;
    mqField      = 1'b0;
    shortStack   = 1'b0;
    ea18Bit      = 1'b0;
    ea23Bit      = 1'b0;
    arx18        = 1'b0;
    sbrCall      = 1'b0;
    condDiagFunc = 1'b0;
    ebusDs       = '0;
    diagStrobe   = 1'b0;
    ebusDataIn   = '0;

    $readmemh("tb/ctlPatterns.mem", patterns);
    if ($isunknown(patterns[0]) || $isunknown(patterns[vectorCount*vectorWords-1])) begin
      fileErrors++;
      $display("The pattern file tb/ctlPatterns.mem is missing or incomplete");
    end

    repeat (5) @(posedge CTL);
    reset <= 1'b0;
    @(negedge CTL);
    waitCount = 0;
    while (!outputsKnown() && waitCount < resetTimeout) begin
      @(negedge CTL);
      waitCount++;
    end
    if (!outputsKnown()) begin
      waitErrors++;
      $display("Timed out waiting for the outputs to become known after reset");
    end
    checkResetState();

    if (fileErrors == 0) begin
      for (int v = 0; v < vectorCount; v++) begin
        base = v * vectorWords;
        currentVector = v;
        @(posedge CTL);
        disp       <= dispCodeT'(patterns[base][4:0]);
        spec       <= specCodeT'(patterns[base+1][4:0]);
        cond       <= condCodeT'(patterns[base+2][2:0]);
        condEn     <= patterns[base+3][0];
        magic      <= patterns[base+4][8:0];
        arField    <= patterns[base+5][2:0];
        arxField   <= patterns[base+6][2:0];
        mqField    <= patterns[base+7][0];
        {shortStack, ea18Bit, ea23Bit, arx18, sbrCall, condDiagFunc} <= patterns[base+8][5:0];
        ebusDs     <= diagFuncT'(patterns[base+9][6:0]);
        diagStrobe <= patterns[base+10][0];
        ebusDataIn <= sliceT'(patterns[base+11][4:0]);
        expFlags   = patterns[base+12][5:0];
        expArlSel  = patterns[base+13][2:0];
        expDriving = patterns[base+14][0];
        expData    = sliceT'(patterns[base+15][4:0]);
        expDiagCtl = diagCtlRegT'(patterns[base+16][4:0]);

        // Low digit of the console code, or of magic when the console is idle
        if (patterns[base+9][6] || patterns[base+9][5]) begin
          expDiag = patterns[base+9][2:0];
        end else begin
          expDiag = patterns[base+4][2:0];
        end

        // Decoded controls land one edge after the inputs
        @(posedge CTL);
        @(negedge CTL);
        checkBit("adLong", adLong, expFlags[5]);
        checkBit("genCry18", genCry18, expFlags[4]);
        checkBit("loadPc", loadPc, expFlags[3]);
        checkBit("dispRet", dispRet, expFlags[2]);
        checkBit("ar00to11Clr", ar00to11Clr, expFlags[1]);
        checkBit("ar12to17Clr", ar12to17Clr, expFlags[0]);
        checkSelect("arlSel", arlSel, expArlSel);
        checkSelect("diag", diag, expDiag);
        checkDiagCtl("diagCtl", diagCtl, expDiagCtl);
        checkBit("channelClkStop", channelClkStop, expDiagCtl.channelClkStop);

        // Bus readback one edge later
        @(posedge CTL);
        @(negedge CTL);
        checkBit("ebusDriving", ebusDriving, expDriving);
        checkSlice("ebusData", ebusData, expData);
      end
    end

    $display("Checks run %0d, check errors %0d, timeouts %0d, file errors %0d",
             checkCount, checkErrors, waitErrors, fileErrors);
    if (checkErrors == 0 && waitErrors == 0 && fileErrors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/ctlPatterns.mem
// disp spec cond condEn magic arField arxField mqField status ebusDs strobe dataIn
//   then expected flags arlSel ebusDriving ebusData diagCtl
// status {shortStack ea18 ea23 arx18 sbrCall condDiagFunc}, flags {adLong genCry18 loadPc dispRet clr00 clr12}
18 00 0 0 000 0 0 0 00 00 0 00 20 0 0 00 00
19 00 0 0 000 0 0 0 00 00 0 00 20 0 0 00 00
1D 00 0 0 000 0 0 0 00 00 0 00 20 0 0 00 00
00 17 0 0 000 0 0 0 00 00 0 00 20 0 0 00 00
00 0A 0 0 000 0 0 0 00 00 0 00 20 0 0 00 00
00 0F 0 0 000 0 0 0 00 00 0 00 10 0 0 00 00
00 10 0 0 000 0 0 0 20 00 0 00 10 0 0 00 00
00 10 0 0 000 0 0 0 00 00 0 00 00 0 0 00 00
00 0D 0 0 000 0 0 0 00 00 0 00 08 0 0 00 00
00 0D 0 0 000 0 0 0 02 00 0 00 00 0 0 00 00
06 00 0 0 000 0 0 0 00 00 0 00 08 0 0 00 00
03 00 0 0 000 0 0 0 02 00 0 00 04 0 0 00 00
03 00 0 0 000 0 0 0 00 00 0 00 00 0 0 00 00
00 00 4 1 000 0 0 0 00 00 0 00 03 0 0 00 00
00 00 4 0 000 0 0 0 00 00 0 00 00 0 0 00 00
00 12 0 0 1C0 2 0 0 00 00 0 00 00 7 0 00 00
00 00 0 0 1C0 2 0 0 00 00 0 00 00 2 0 00 00
00 00 6 1 0C0 5 0 0 00 00 0 00 00 3 0 00 00
1E 00 0 0 000 0 0 0 04 00 0 00 03 0 0 00 00
00 00 0 0 000 0 0 0 00 3E 1 0D 00 0 0 00 0D
00 00 0 0 000 0 0 0 00 3E 0 12 00 0 0 00 0D
00 00 0 0 000 0 0 0 00 3E 1 16 00 0 0 00 16
18 00 7 1 142 1 6 0 00 40 1 00 20 1 1 03 16
18 00 7 1 142 1 6 0 00 41 1 00 20 1 1 0F 16
18 00 7 1 142 1 6 0 00 42 1 00 20 1 1 12 16
18 00 7 1 142 1 6 0 00 43 1 00 20 1 1 06 16
18 00 7 1 142 1 6 0 00 44 1 00 20 1 1 1C 16
18 00 7 1 142 1 6 0 00 45 1 00 20 1 1 16 16
18 00 7 1 142 1 6 0 00 46 1 00 20 1 1 16 16
18 00 7 1 142 1 6 0 00 47 1 00 20 1 1 16 16
18 00 7 1 142 1 6 0 00 48 1 00 20 1 0 00 16
03 0F 0 0 040 2 1 1 03 00 0 00 14 2 1 1F 16
03 0F 0 0 042 2 1 1 03 00 0 00 14 2 1 06 16
03 0F 0 0 044 2 1 1 03 00 0 00 14 2 1 02 16
03 0F 0 0 046 2 1 1 03 00 0 00 14 2 1 16 16

//--- flist.f
+incdir+common
common/ctlCramPkg.sv
common/ctlDiagPkg.sv
microDecode/microDecode.sv
diagDecode/diagDecode.sv
source/ebusReadback.sv
source/ctlTop.sv
tb/ctlTb.sv

//--- Makefile
TOOL      := verilator
TOP       := ctlTb
FLIST     := flist.f
FLAGS     := --binary --timing --timescale 1ns/1ps
LINTFLAGS := --lint-only --timing --timescale 1ns/1ps
BUILD     := obj_dir
LOG       := sim.log

.PHONY: lint build sim clean

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

sim: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG) || ! grep -q ">>> PASS" $(LOG); then \
		echo "Simulation reported errors, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
